/* verilog/cart_pkg.sv */
`default_nettype none

package cart_pkg;

	// ************************************************************
	// Bus and bank widths
	// ************************************************************
	typedef logic [15:0] c64_addr_t;    // CPU bus address
	typedef logic [7:0]  c64_data_t;    // CPU data byte
	typedef logic [23:0] sdram_addr_t;  // Translated SDRAM address
	typedef logic [7:0]  bank_t;        // 8 KB bank in the cartridge region
	typedef logic [15:0] cart_id_t;     // CRT hardware type

	// Bank table
	localparam int BANK_TABLE_DEPTH = 64;
	localparam int BANK_INDEX_W     = 6;

	// ************************************************************
	// CRT hardware types
	// ************************************************************
	localparam cart_id_t CART_GENERIC    = 16'd0;
	localparam cart_id_t CART_OCEAN      = 16'd5;
	localparam cart_id_t CART_EPYX       = 16'd10;
	localparam cart_id_t CART_MAGIC_DESK = 16'd19;
	localparam cart_id_t CART_EASYFLASH  = 16'd32;
	localparam cart_id_t CART_XBANK      = 16'd33;

	// Epyx capacitor discharge time in clk32 cycles
	localparam logic [15:0] EPYX_DISCHARGE_CYCLES = 16'd16384;

	// Chip packet decoding
	localparam c64_addr_t   ROM_LO_LOAD_LIMIT = 16'h8000;  // Highest ROML load address
	localparam logic [15:0] BANK8K_SIZE       = 16'h2000;  // Larger packets also fill ROMH

endpackage

`default_nettype wire

/* verilog/cart_bank_table.sv */
`timescale 1ns/1ps
`default_nettype none

module cart_bank_table (
	input  logic                              clk32,
	input  logic                              cart_loading,
	input  logic                              cart_bank_wr,
	input  logic [15:0]                       cart_bank_num,
	input  cart_pkg::c64_addr_t               cart_bank_laddr,
	input  logic [15:0]                       cart_bank_size,
	input  cart_pkg::sdram_addr_t             cart_bank_raddr,
	input  logic [cart_pkg::BANK_INDEX_W-1:0] table_index,
	output cart_pkg::bank_t                   lo_entry,
	output cart_pkg::bank_t                   hi_entry,
	output logic [7:0]                        bank_cnt
);
	import cart_pkg::*;

	bank_t lo_table [BANK_TABLE_DEPTH];  // Banks seen at $8000
	bank_t hi_table [BANK_TABLE_DEPTH];  // Banks seen at $A000 / $E000

	logic                    old_loading;
	bank_t                   raddr_bank;
	logic [BANK_INDEX_W-1:0] wr_index;

	// 8 KB bank number of the packet inside the SDRAM cartridge region
	assign raddr_bank = cart_bank_raddr[20:13];
	assign wr_index   = cart_bank_num[BANK_INDEX_W-1:0];

	always_ff @(posedge clk32) begin
		old_loading <= cart_loading;

		// New image starts, count from zero
		if (cart_loading && !old_loading)
			bank_cnt <= 8'd0;

		if (cart_bank_wr) begin
			bank_cnt <= bank_cnt + 8'd1;  // Every packet counts
			if (cart_bank_num < BANK_TABLE_DEPTH) begin
				if (cart_bank_laddr <= ROM_LO_LOAD_LIMIT) begin
					lo_table[wr_index] <= raddr_bank;
					// 16 KB packet spills into ROMH
					if (cart_bank_size > BANK8K_SIZE)
						hi_table[wr_index] <= raddr_bank + 8'd1;
				end else begin
					hi_table[wr_index] <= raddr_bank;
				end
			end
		end
	end

	assign lo_entry = lo_table[table_index];
	assign hi_entry = hi_table[table_index];

endmodule

`default_nettype wire

/* verilog/cart_mapper.sv */
`timescale 1ns/1ps
`default_nettype none

module cart_mapper (
	input  logic                              clk32,
	input  logic                              reset,
	input  logic                              ioe,
	input  logic                              iof,
	input  logic                              rom_l,
	input  logic                              mem_write,
	input  cart_pkg::cart_id_t                cart_id,
	input  cart_pkg::c64_data_t               cart_exrom,
	input  cart_pkg::c64_data_t               cart_game,
	input  cart_pkg::c64_addr_t               c64_mem_address_in,
	input  cart_pkg::c64_data_t               c64_data_out,
	input  logic [7:0]                        bank_cnt,
	input  cart_pkg::bank_t                   lo_entry,
	input  cart_pkg::bank_t                   hi_entry,
	output logic [cart_pkg::BANK_INDEX_W-1:0] table_index,
	output cart_pkg::bank_t                   bank_lo,
	output cart_pkg::bank_t                   bank_hi,
	output cart_pkg::bank_t                   ioe_bank,
	output cart_pkg::bank_t                   iof_bank,
	output logic                              ioe_ena,
	output logic                              iof_ena,
	output logic                              iof_wr_ena,
	output logic                              exrom_override,
	output logic                              game_override
);
	import cart_pkg::*;

	logic        old_ioe;
	logic        ioe_wr;
	logic        is_easyflash;
	logic        init_n;     // Low in the first cycle after reset
	logic        count_ena;  // Epyx capacitor has been charged once
	logic [15:0] count;

	// ************************************************************
	// IO strobe detection
	// ************************************************************
	always_ff @(posedge clk32)
		old_ioe <= ioe;

	assign ioe_wr = ioe && !old_ioe && mem_write;

	assign is_easyflash = (cart_id == CART_EASYFLASH) || (cart_id == CART_XBANK);

	// EasyFlash bank register picks a table row, all other reads use row 0
	assign table_index = (is_easyflash && ioe_wr && !c64_mem_address_in[1]) ?
		c64_data_out[BANK_INDEX_W-1:0] : '0;

	// No kept type maps the IOE window into ROM
	assign ioe_ena  = 1'b0;
	assign ioe_bank = 8'd0;

	// ************************************************************
	// Per-type bank and EXROM/GAME registers
	// ************************************************************
	always_ff @(posedge clk32) begin
		if (!reset) begin
			bank_lo        <= 8'd0;
			bank_hi        <= 8'd0;
			iof_bank       <= 8'd0;
			iof_ena        <= 1'b0;
			iof_wr_ena     <= 1'b0;
			exrom_override <= 1'b1;
			game_override  <= 1'b1;
			count_ena      <= 1'b0;
			init_n         <= 1'b0;
		end else begin
			init_n <= 1'b1;
			case (cart_id)
				CART_GENERIC: begin  // Lines straight from the CRT header
					exrom_override <= cart_exrom[0];
					game_override  <= cart_game[0];
					bank_lo        <= lo_entry;
					bank_hi        <= hi_entry;
				end

				CART_OCEAN: begin  // Same bank mirrored at $8000 and $A000
					exrom_override <= 1'b0;
					game_override  <= 1'b0;
					if (ioe_wr) begin
						bank_lo <= {2'b00, c64_data_out[5:0]};
						bank_hi <= {2'b00, c64_data_out[5:0]};
					end
				end

				CART_EPYX: begin
					if (!init_n)
						count_ena <= 1'b0;
					if (rom_l || ioe)
						count_ena <= 1'b1;

					// ROML or IOE recharges the capacitor
					if (!init_n || rom_l || ioe) begin
						game_override  <= 1'b1;
						exrom_override <= 1'b0;
						count          <= EPYX_DISCHARGE_CYCLES;
						iof_ena        <= 1'b1;
						iof_bank       <= 8'd0;
					end else if (count_ena && !iof) begin  // IO2 reads hold the charge
						if (count != 16'd0)
							count <= count - 16'd1;
						else
							exrom_override <= 1'b1;  // Discharged, cart drops out
					end
				end

				CART_MAGIC_DESK: begin
					if (!init_n) begin
						game_override  <= 1'b1;
						exrom_override <= 1'b0;
						bank_lo        <= 8'd0;
					end
					if (ioe_wr) begin
						// Bank register width follows the image size
						if (bank_cnt <= 8'd16)
							bank_lo <= {4'd0, c64_data_out[3:0]};
						else if (bank_cnt <= 8'd32)
							bank_lo <= {3'd0, c64_data_out[4:0]};
						else if (bank_cnt <= 8'd64)
							bank_lo <= {2'd0, c64_data_out[5:0]};
						else
							bank_lo <= {1'b0, c64_data_out[6:0]};
						exrom_override <= c64_data_out[7];
					end
				end

				CART_EASYFLASH, CART_XBANK: begin
					if (!init_n) begin
						iof_bank       <= 8'd0;  // IO2 RAM page
						iof_ena        <= 1'b1;
						iof_wr_ena     <= 1'b1;
						exrom_override <= (cart_id == CART_EASYFLASH);  // Ultimax boot
						game_override  <= 1'b0;
						bank_lo        <= lo_entry;
						bank_hi        <= hi_entry;
					end
					if (ioe_wr) begin
						if (c64_mem_address_in[1]) begin  // $DE02 control
							game_override  <= !c64_data_out[0] && c64_data_out[2];
							exrom_override <= !c64_data_out[1];
						end else begin                    // $DE00 bank
							bank_lo <= lo_entry;
							bank_hi <= hi_entry;
						end
					end
				end

				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

/* verilog/cart_addr_map.sv */
`timescale 1ns/1ps
`default_nettype none

module cart_addr_map (
	input  logic                  cart_attached,
	input  logic                  rom_l,
	input  logic                  rom_h,
	input  logic                  ioe,
	input  logic                  iof,
	input  logic                  mem_write,
	input  logic                  mem_ce,
	input  cart_pkg::c64_addr_t   c64_mem_address_in,
	input  cart_pkg::bank_t       bank_lo,
	input  cart_pkg::bank_t       bank_hi,
	input  cart_pkg::bank_t       ioe_bank,
	input  cart_pkg::bank_t       iof_bank,
	input  logic                  ioe_ena,
	input  logic                  iof_ena,
	input  logic                  iof_wr_ena,
	output cart_pkg::sdram_addr_t sdram_address_out,
	output logic                  mem_ce_out
);
	import cart_pkg::*;

	logic ioe_ce;
	logic iof_ce;

	assign ioe_ce = ioe && ioe_ena;
	assign iof_ce = iof && (mem_write ? iof_wr_ena : iof_ena);

	assign mem_ce_out = mem_ce || ioe_ce || iof_ce;

	// Cartridge region sits above 8 MB, banks fill bits 20..13
	always_comb begin
		sdram_address_out = {8'd0, c64_mem_address_in};  // Plain RAM access
		if (cart_attached) begin
			if (rom_h && !mem_write)
				sdram_address_out[23:13] = {3'b100, bank_hi};
			if (rom_l && !mem_write)
				sdram_address_out[23:13] = {3'b100, bank_lo};
			if (ioe_ce)
				sdram_address_out[23:13] = {3'b100, ioe_bank};  // $DExx
			if (iof_ce)  // $DFxx, writable RAM stays in the low banks
				sdram_address_out[23:13] = iof_wr_ena ?
					{3'b100, 5'd0, iof_bank[2:0]} : {3'b100, iof_bank};
		end
	end

endmodule

`default_nettype wire

/* verilog/cartridge.sv */
`timescale 1ns/1ps
`default_nettype none

module cartridge (
	input  logic                  clk32,
	input  logic                  reset,
	input  logic                  rom_l,
	input  logic                  rom_h,
	input  logic                  ioe,
	input  logic                  iof,
	input  logic                  mem_write,
	input  logic                  mem_ce,
	input  cart_pkg::cart_id_t    cart_id,
	input  cart_pkg::c64_data_t   cart_exrom,  // CRT header EXROM
	input  cart_pkg::c64_data_t   cart_game,   // CRT header GAME
	input  logic [15:0]           cart_bank_num,
	input  cart_pkg::c64_addr_t   cart_bank_laddr,
	input  logic [15:0]           cart_bank_size,
	input  cart_pkg::sdram_addr_t cart_bank_raddr,
	input  logic                  cart_bank_wr,
	input  logic                  cart_attached,
	input  logic                  cart_loading,
	input  cart_pkg::c64_addr_t   c64_mem_address_in,
	input  cart_pkg::c64_data_t   c64_data_out,
	output cart_pkg::sdram_addr_t sdram_address_out,
	output logic                  mem_ce_out,
	output logic                  exrom,
	output logic                  game,
	output logic                  ioe_ena,
	output logic                  iof_ena
);
	import cart_pkg::*;

	logic [BANK_INDEX_W-1:0] table_index;
	logic [7:0]              bank_cnt;
	bank_t                   lo_entry;
	bank_t                   hi_entry;
	bank_t                   bank_lo;
	bank_t                   bank_hi;
	bank_t                   ioe_bank;
	bank_t                   iof_bank;
	logic                    iof_wr_ena;
	logic                    exrom_override;
	logic                    game_override;

	// ************************************************************
	// Bank table, mapper registers and address translation
	// ************************************************************
	cart_bank_table u_bank_table (
		.clk32           (clk32),
		.cart_loading    (cart_loading),
		.cart_bank_wr    (cart_bank_wr),
		.cart_bank_num   (cart_bank_num),
		.cart_bank_laddr (cart_bank_laddr),
		.cart_bank_size  (cart_bank_size),
		.cart_bank_raddr (cart_bank_raddr),
		.table_index     (table_index),
		.lo_entry        (lo_entry),
		.hi_entry        (hi_entry),
		.bank_cnt        (bank_cnt)
	);

	cart_mapper u_mapper (
		.clk32              (clk32),
		.reset              (reset),
		.ioe                (ioe),
		.iof                (iof),
		.rom_l              (rom_l),
		.mem_write          (mem_write),
		.cart_id            (cart_id),
		.cart_exrom         (cart_exrom),
		.cart_game          (cart_game),
		.c64_mem_address_in (c64_mem_address_in),
		.c64_data_out       (c64_data_out),
		.bank_cnt           (bank_cnt),
		.lo_entry           (lo_entry),
		.hi_entry           (hi_entry),
		.table_index        (table_index),
		.bank_lo            (bank_lo),
		.bank_hi            (bank_hi),
		.ioe_bank           (ioe_bank),
		.iof_bank           (iof_bank),
		.ioe_ena            (ioe_ena),
		.iof_ena            (iof_ena),
		.iof_wr_ena         (iof_wr_ena),
		.exrom_override     (exrom_override),
		.game_override      (game_override)
	);

	cart_addr_map u_addr_map (
		.cart_attached      (cart_attached),
		.rom_l              (rom_l),
		.rom_h              (rom_h),
		.ioe                (ioe),
		.iof                (iof),
		.mem_write          (mem_write),
		.mem_ce             (mem_ce),
		.c64_mem_address_in (c64_mem_address_in),
		.bank_lo            (bank_lo),
		.bank_hi            (bank_hi),
		.ioe_bank           (ioe_bank),
		.iof_bank           (iof_bank),
		.ioe_ena            (ioe_ena),
		.iof_ena            (iof_ena),
		.iof_wr_ena         (iof_wr_ena),
		.sdram_address_out  (sdram_address_out),
		.mem_ce_out         (mem_ce_out)
	);

	// Open-collector lines read high with no cartridge
	assign exrom = !cart_attached || exrom_override;
	assign game  = !cart_attached || game_override;

endmodule

`default_nettype wire

/* sim/cartridge_props.sv */
`timescale 1ns/1ps
`default_nettype none

module cartridge_props (
	input logic clk32,
	input logic reset,
	input logic exrom,
	input logic game,
	input logic mem_ce,
	input logic ioe,
	input logic iof,
	input logic mem_ce_out,
	input logic ioe_ena,
	input logic iof_ena
);
	int fail_cnt = 0;  // Assertion failures so far

	// ************************************************************
	// Expansion port lines and chip enables
	// ************************************************************
	lines_high_after_reset: assert property (@(posedge clk32) !reset |=> (exrom && game))
		else begin
			$error("exrom or game is low in the cycle after reset");
			fail_cnt++;
		end

	// IO chip enable only inside a window the mapper has opened
	io_ce_needs_window: assert property (@(posedge clk32)
			(mem_ce_out && !mem_ce) |-> ((ioe && ioe_ena) || (iof && iof_ena)))
		else begin
			$error("mem_ce_out is high for an IO access outside an enabled window");
			fail_cnt++;
		end

	io_off_after_reset: assert property (@(posedge clk32) !reset |=> (!ioe_ena && !iof_ena))
		else begin
			$error("ioe_ena or iof_ena is high in the cycle after reset");
			fail_cnt++;
		end

endmodule

bind cartridge cartridge_props u_props (
	.clk32         (clk32),
	.reset         (reset),
	.exrom         (exrom),
	.game          (game),
	.mem_ce        (mem_ce),
	.ioe           (ioe),
	.iof           (iof),
	.mem_ce_out    (mem_ce_out),
	.ioe_ena       (ioe_ena),
	.iof_ena       (iof_ena)
);

`default_nettype wire

/* sim/cartridge_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cartridge_tb;
	import cart_pkg::*;

	localparam int        CLK_PERIOD   = 20;
	localparam int        RESET_CYCLES = 3;
	localparam int        CHECK_DELAY  = CLK_PERIOD / 4;  // Sample point after the falling edge
	localparam c64_addr_t RANDOM_MASK  = 16'h1ffc;        // Offset bits kept by every mapping
	localparam string     TRACE_FILE   = "sim/cartridge_trace.txt";

	logic        clk32;
	logic        reset;
	logic        rom_l;
	logic        rom_h;
	logic        ioe;
	logic        iof;
	logic        mem_write;
	logic        mem_ce;
	cart_id_t    cart_id;
	c64_data_t   cart_exrom;
	c64_data_t   cart_game;
	logic [15:0] cart_bank_num;
	c64_addr_t   cart_bank_laddr;
	logic [15:0] cart_bank_size;
	sdram_addr_t cart_bank_raddr;
	logic        cart_bank_wr;
	logic        cart_attached;
	logic        cart_loading;
	c64_addr_t   c64_mem_address_in;
	c64_data_t   c64_data_out;
	sdram_addr_t sdram_address_out;
	logic        mem_ce_out;
	logic        exrom;
	logic        game;
	logic        ioe_ena;
	logic        iof_ena;

	int errors;
	int timeout_cycles;

	cartridge dut (
		.clk32              (clk32),
		.reset              (reset),
		.rom_l              (rom_l),
		.rom_h              (rom_h),
		.ioe                (ioe),
		.iof                (iof),
		.mem_write          (mem_write),
		.mem_ce             (mem_ce),
		.cart_id            (cart_id),
		.cart_exrom         (cart_exrom),
		.cart_game          (cart_game),
		.cart_bank_num      (cart_bank_num),
		.cart_bank_laddr    (cart_bank_laddr),
		.cart_bank_size     (cart_bank_size),
		.cart_bank_raddr    (cart_bank_raddr),
		.cart_bank_wr       (cart_bank_wr),
		.cart_attached      (cart_attached),
		.cart_loading       (cart_loading),
		.c64_mem_address_in (c64_mem_address_in),
		.c64_data_out       (c64_data_out),
		.sdram_address_out  (sdram_address_out),
		.mem_ce_out         (mem_ce_out),
		.exrom              (exrom),
		.game               (game),
		.ioe_ena            (ioe_ena),
		.iof_ena            (iof_ena)
	);

	always #(CLK_PERIOD / 2) clk32 = !clk32;

	// ************************************************************
	// Checks
	// ************************************************************
	task automatic check_value(input string name, input logic [23:0] expected,
			input logic [23:0] actual);
		assert (actual === expected) else begin
			$display("ERROR %s: expected %h, got %h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic check_fields(input int got, input int want);
		assert (got == want) else begin
			$display("A trace line has %0d fields where %0d were expected", got, want);
			errors++;
		end
	endtask

	// IOF window is opened by Epyx and by the EasyFlash family only
	function automatic logic iof_window_open(input cart_id_t id);
		return (id == CART_EPYX) || (id == CART_EASYFLASH) || (id == CART_XBANK);
	endfunction

	task automatic compare_status(input logic exp_exrom, input logic exp_game);
		check_value("exrom", 24'(exp_exrom), 24'(exrom));
		check_value("game", 24'(exp_game), 24'(game));
		check_value("ioe_ena", 24'd0, 24'(ioe_ena));  // No kept type maps IOE
		check_value("iof_ena", 24'(iof_window_open(cart_id)), 24'(iof_ena));
	endtask

	task automatic expect_lines(input logic exp_exrom, input logic exp_game);
		@(negedge clk32);
		#(CHECK_DELAY);
		compare_status(exp_exrom, exp_game);
	endtask

	// ************************************************************
	// Stimulus
	// ************************************************************
	task automatic drive_idle();
		rom_l     = 1'b0;
		rom_h     = 1'b0;
		ioe       = 1'b0;
		iof       = 1'b0;
		mem_write = 1'b0;
		mem_ce    = 1'b0;
	endtask

	// New hardware type always goes through a reset
	task automatic restart_type(input cart_id_t id, input c64_data_t exr, input c64_data_t gm);
		@(negedge clk32);
		cart_id       = id;
		cart_exrom    = exr;
		cart_game     = gm;
		cart_attached = 1'b1;
		reset         = 1'b0;
		repeat (RESET_CYCLES) @(negedge clk32);
		reset = 1'b1;
	endtask

	task automatic start_image();
		@(negedge clk32);
		cart_loading = 1'b1;  // Rising edge clears the bank count
		@(negedge clk32);
		cart_loading = 1'b0;
	endtask

	task automatic load_packets(input logic [15:0] num, input c64_addr_t laddr,
			input logic [15:0] size, input sdram_addr_t raddr, input int count);
		int i;
		for (i = 0; i < count; i++) begin
			@(negedge clk32);
			cart_bank_num   = num + 16'(i);
			cart_bank_laddr = laddr;
			cart_bank_size  = size;
			cart_bank_raddr = raddr + (sdram_addr_t'(i) << 13);  // Next 8 KB bank
			cart_bank_wr    = 1'b1;
			@(negedge clk32);
			cart_bank_wr    = 1'b0;
		end
	endtask

	task automatic bus_access(input logic [7:0] flags, input c64_addr_t addr,
			input c64_data_t data, input sdram_addr_t exp_addr, input logic exp_ce,
			input logic exp_exrom, input logic exp_game);
		c64_addr_t rnd_bits;
		rnd_bits = c64_addr_t'($urandom()) & RANDOM_MASK;
		@(negedge clk32);
		rom_l              = flags[0];
		rom_h              = flags[1];
		ioe                = flags[2];
		iof                = flags[3];
		mem_write          = flags[4];
		mem_ce             = flags[5];
		cart_attached      = flags[6];
		c64_mem_address_in = addr ^ rnd_bits;
		c64_data_out       = data;
		#(CHECK_DELAY);
		check_value("sdram_address_out", exp_addr ^ {8'd0, rnd_bits}, sdram_address_out);
		check_value("mem_ce_out", 24'(exp_ce), 24'(mem_ce_out));
		@(negedge clk32);
		drive_idle();
		#(CHECK_DELAY);
		compare_status(exp_exrom, exp_game);  // Registers updated on the strobe edge
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(negedge clk32);
	endtask

	// ************************************************************
	// Trace interpreter
	// ************************************************************
	task automatic run_trace(input int fd);
		logic [7:0]       cmd;
		logic [31:0]      field [8];
		logic [8*128-1:0] rest;
		int               got;
		while (!$feof(fd)) begin
			cmd = 8'd0;
			got = $fscanf(fd, "%s", cmd);
			if (got == 1) begin
				if (cmd == "#") begin
					got = $fgets(rest, fd);
				end else if (cmd == "T") begin
					got = $fscanf(fd, "%h %h %h", field[0], field[1], field[2]);
					check_fields(got, 3);
					restart_type(cart_id_t'(field[0]), c64_data_t'(field[1]),
						c64_data_t'(field[2]));
				end else if (cmd == "N") begin
					start_image();
				end else if (cmd == "L") begin
					got = $fscanf(fd, "%h %h %h %h %h", field[0], field[1], field[2],
						field[3], field[4]);
					check_fields(got, 5);
					load_packets(16'(field[0]), c64_addr_t'(field[1]), 16'(field[2]),
						sdram_addr_t'(field[3]), int'(field[4]));
				end else if (cmd == "A") begin
					got = $fscanf(fd, "%h %h %h %h %h %h %h", field[0], field[1], field[2],
						field[3], field[4], field[5], field[6]);
					check_fields(got, 7);
					bus_access(8'(field[0]), c64_addr_t'(field[1]), c64_data_t'(field[2]),
						sdram_addr_t'(field[3]), 1'(field[4]), 1'(field[5]), 1'(field[6]));
				end else if (cmd == "I") begin
					got = $fscanf(fd, "%h", field[0]);
					check_fields(got, 1);
					idle_cycles(int'(field[0]));
				end else if (cmd == "E") begin
					got = $fscanf(fd, "%h %h", field[0], field[1]);
					check_fields(got, 2);
					expect_lines(1'(field[0]), 1'(field[1]));
				end else begin
					$display("Unknown command %s in the trace file", cmd);
					errors++;
				end
			end
		end
	endtask

	initial begin
		int               fd;
		int               line_cnt;
		logic [8*128-1:0] text;
		errors         = 0;
		timeout_cycles = 0;
		void'($urandom(32'h1611));
		clk32              = 1'b0;
		reset              = 1'b0;
		drive_idle();
		cart_id            = CART_GENERIC;
		cart_exrom         = 8'd0;
		cart_game          = 8'd0;
		cart_bank_num      = 16'd0;
		cart_bank_laddr    = 16'd0;
		cart_bank_size     = 16'd0;
		cart_bank_raddr    = 24'd0;
		cart_bank_wr       = 1'b0;
		cart_attached      = 1'b0;
		cart_loading       = 1'b0;
		c64_mem_address_in = 16'd0;
		c64_data_out       = 8'd0;

		fd = $fopen(TRACE_FILE, "r");
		if (fd == 0) begin
			$display("Cannot open the trace file %s", TRACE_FILE);
			errors++;
		end else begin
			line_cnt = 0;
			while (!$feof(fd)) begin
				if ($fgets(text, fd) != 0)
					line_cnt++;
			end
			$fclose(fd);
			timeout_cycles = line_cnt * 40 + int'(EPYX_DISCHARGE_CYCLES) + 200;

			repeat (RESET_CYCLES) @(negedge clk32);
			reset = 1'b1;
			fd = $fopen(TRACE_FILE, "r");
			run_trace(fd);
			$fclose(fd);
		end

		$display("Errors: %0d in checks, %0d in assertions", errors, dut.u_props.fail_cnt);
		if (errors == 0 && dut.u_props.fail_cnt == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

	// Watchdog, armed once the trace length is known
	initial begin
		wait (timeout_cycles != 0);
		repeat (timeout_cycles) @(posedge clk32);
		$display("Timeout: the trace did not finish within %0d clock cycles", timeout_cycles);
		$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

/* flist.f */
verilog/cart_pkg.sv
verilog/cart_bank_table.sv
verilog/cart_mapper.sv
verilog/cart_addr_map.sv
verilog/cartridge.sv
sim/cartridge_props.sv
sim/cartridge_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= cartridge_tb
OBJ_DIR   ?= obj_dir
FLIST     ?= flist.f
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= Testbench passed

SOURCES := $(shell cat $(FLIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* sim/cartridge_trace.txt */
# T id exrom game | N | L num laddr size raddr count | I cycles | E exrom game (all hex)
# A flags addr data exp_addr exp_ce exp_exrom exp_game; flags 0 roml 1 romh 2 ioe 3 iof 4 wr 5 ce 6 att
T 0 0 1
N
L 0 8000 4000 806000 1
E 0 1
A 61 8123 00 806123 1 0 1
A 62 a456 00 808456 1 0 1
A 21 8123 00 008123 1 1 1
T 5 0 0
A 54 de00 ea 00de00 0 0 0
A 61 8010 00 854010 1 0 0
A 62 a020 00 854020 1 0 0
T 13 0 0
N
L 0 8000 2000 810000 10
A 54 de00 ff 00de00 0 1 1
A 61 8000 00 81e000 1 1 1
N
L 0 8000 2000 810000 28
A 54 de00 7f 00de00 0 0 1
A 61 8000 00 87e000 1 0 1
N
L 0 a000 2000 840000 8
T 20 0 0
E 1 0
A 54 de00 05 00de00 0 1 0
A 61 8000 00 81a000 1 1 0
A 62 a000 00 84a000 1 1 0
A 54 de02 04 00de02 0 1 1
A 54 de02 02 00de02 0 0 0
A 48 df10 00 801f10 1 0 0
A 58 df20 33 801f20 1 0 0
T 21 0 0
E 0 0
T a 0 0
A 61 8000 00 800000 1 0 1
I 20
A 61 8004 00 800004 1 0 1
I 3ff6
E 0 1
I 14
E 1 1
